//--- Makefile
# Verilator build and run for the decode/execute slice

VERILATOR ?= verilator
TOP       ?= tb_rv_core_slice
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the binary exits nonzero when the testbench stops with $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hdl/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data path width, fixed by RV32
`define RV_XLEN 32

// RV32E has sixteen integer registers
`define RV_NREG 16

// register index width, bit 4 of the encoded index is not used
`define RV_REG_W 4

// writers in flight per register
// one in execute and one in writeback, so counts stay at 2 or below
`define RV_CNT_W 2

`endif

//--- hdl/rv_core_slice.sv
`timescale 1ns/1ps

module rv_core_slice (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  input  rv_pipe_pkg::inst_t    inst_i,
  input  rv_pipe_pkg::word_t    pc_i,
  output logic                  inst_ready_o,
  output logic                  retire_valid_o,
  output rv_pipe_pkg::word_t    retire_pc_o,
  output rv_pipe_pkg::reg_idx_t retire_rd_o,
  output rv_pipe_pkg::word_t    retire_data_o,
  output logic                  retire_we_o,
  output logic                  retire_illegal_o,
  input  logic                  retire_ready_i
);
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  // register file read side
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rdata1;
  word_t    rdata2;
  rf_busy_t busy;

  // decode to execute
  logic     issue_valid;
  alu_op_e  issue_alu_op;
  word_t    issue_op1;
  word_t    issue_op2;
  reg_idx_t issue_rd;
  logic     issue_we;
  logic     issue_illegal;
  word_t    issue_pc;
  logic     exu_ready;

  // execute back to decode and to the register file
  logic     fwd_valid;
  reg_idx_t fwd_rd;
  word_t    fwd_data;
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // scoreboard marks rd on the issue handshake
  wire sb_set = issue_valid & exu_ready & issue_we;

  rv_idu u_idu (
    .clk             (clk),
    .rst             (rst),
    .inst_valid_i    (inst_valid_i),
    .inst_i          (inst_i),
    .pc_i            (pc_i),
    .inst_ready_o    (inst_ready_o),
    .rs1_o           (rs1),
    .rs2_o           (rs2),
    .rdata1_i        (rdata1),
    .rdata2_i        (rdata2),
    .busy_i          (busy),
    .fwd_valid_i     (fwd_valid),
    .fwd_rd_i        (fwd_rd),
    .fwd_data_i      (fwd_data),
    .issue_valid_o   (issue_valid),
    .issue_alu_op_o  (issue_alu_op),
    .issue_op1_o     (issue_op1),
    .issue_op2_o     (issue_op2),
    .issue_rd_o      (issue_rd),
    .issue_we_o      (issue_we),
    .issue_illegal_o (issue_illegal),
    .issue_pc_o      (issue_pc),
    .exu_ready_i     (exu_ready)
  );

  rv_exu u_exu (
    .clk              (clk),
    .rst              (rst),
    .issue_valid_i    (issue_valid),
    .issue_alu_op_i   (issue_alu_op),
    .issue_op1_i      (issue_op1),
    .issue_op2_i      (issue_op2),
    .issue_rd_i       (issue_rd),
    .issue_we_i       (issue_we),
    .issue_illegal_i  (issue_illegal),
    .issue_pc_i       (issue_pc),
    .exu_ready_o      (exu_ready),
    .fwd_valid_o      (fwd_valid),
    .fwd_rd_o         (fwd_rd),
    .fwd_data_o       (fwd_data),
    .wb_we_o          (wb_we),
    .wb_rd_o          (wb_rd),
    .wb_data_o        (wb_data),
    .retire_valid_o   (retire_valid_o),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_we_o      (retire_we_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_ready_i   (retire_ready_i)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2),
    .we_i     (wb_we),
    .waddr_i  (wb_rd),
    .wdata_i  (wb_data)
  );

  rv_scoreboard u_scoreboard (
    .clk      (clk),
    .rst      (rst),
    .set_i    (sb_set),
    .set_rd_i (issue_rd),
    .clr_i    (wb_we),
    .clr_rd_i (wb_rd),
    .busy_o   (busy)
  );

endmodule

//--- hdl/rv_exu.sv
`timescale 1ns/1ps

module rv_exu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid_i,
  input  rv_isa_pkg::alu_op_e   issue_alu_op_i,
  input  rv_pipe_pkg::word_t    issue_op1_i,
  input  rv_pipe_pkg::word_t    issue_op2_i,
  input  rv_pipe_pkg::reg_idx_t issue_rd_i,
  input  logic                  issue_we_i,
  input  logic                  issue_illegal_i,
  input  rv_pipe_pkg::word_t    issue_pc_i,
  output logic                  exu_ready_o,
  output logic                  fwd_valid_o,
  output rv_pipe_pkg::reg_idx_t fwd_rd_o,
  output rv_pipe_pkg::word_t    fwd_data_o,
  output logic                  wb_we_o,
  output rv_pipe_pkg::reg_idx_t wb_rd_o,
  output rv_pipe_pkg::word_t    wb_data_o,
  output logic                  retire_valid_o,
  output rv_pipe_pkg::word_t    retire_pc_o,
  output rv_pipe_pkg::reg_idx_t retire_rd_o,
  output rv_pipe_pkg::word_t    retire_data_o,
  output logic                  retire_we_o,
  output logic                  retire_illegal_o,
  input  logic                  retire_ready_i
);
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  word_t      alu_res;
  logic [4:0] shamt;
  logic       ex_valid;
  logic       ex_ready;
  reg_idx_t   ex_rd;
  word_t      ex_res;
  word_t      ex_pc;
  logic       ex_we;
  logic       ex_illegal;
  logic       wb_valid;
  logic       wb_ready;
  reg_idx_t   wb_rd;
  word_t      wb_res;
  word_t      wb_pc;
  logic       wb_we;
  logic       wb_illegal;

  assign shamt = issue_op2_i[4:0];

  always_comb begin
    case (issue_alu_op_i)
      ALU_ADD:  alu_res = issue_op1_i + issue_op2_i;
      ALU_SUB:  alu_res = issue_op1_i - issue_op2_i;
      ALU_SLL:  alu_res = issue_op1_i << shamt;
      ALU_SLT:  alu_res = word_t'($signed(issue_op1_i) < $signed(issue_op2_i));
      ALU_SLTU: alu_res = word_t'(issue_op1_i < issue_op2_i);
      ALU_XOR:  alu_res = issue_op1_i ^ issue_op2_i;
      ALU_SRL:  alu_res = issue_op1_i >> shamt;
      ALU_SRA:  alu_res = word_t'($signed(issue_op1_i) >>> shamt);
      ALU_OR:   alu_res = issue_op1_i | issue_op2_i;
      ALU_AND:  alu_res = issue_op1_i & issue_op2_i;
      // unused funct7 codes fall back to add
      default:  alu_res = issue_op1_i + issue_op2_i;
    endcase
  end

  // a stage can take a new entry when empty or when it drains this cycle
  assign wb_ready    = ~wb_valid | retire_ready_i;
  assign ex_ready    = ~ex_valid | wb_ready;
  assign exu_ready_o = ex_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      if (ex_ready) begin
        ex_valid <= issue_valid_i;
      end
      if (wb_ready) begin
        wb_valid <= ex_valid;
      end
    end
  end

  // execute and writeback payload
  always_ff @(posedge clk) begin
    if (ex_ready && issue_valid_i) begin
      ex_rd      <= issue_rd_i;
      ex_res     <= alu_res;
      ex_pc      <= issue_pc_i;
      ex_we      <= issue_we_i;
      ex_illegal <= issue_illegal_i;
    end
    if (wb_ready && ex_valid) begin
      wb_rd      <= ex_rd;
      wb_res     <= ex_res;
      wb_pc      <= ex_pc;
      wb_we      <= ex_we;
      wb_illegal <= ex_illegal;
    end
  end

  // forwarding source for decode, only writers with a real rd
  assign fwd_valid_o = ex_valid & ex_we;
  assign fwd_rd_o    = ex_rd;
  assign fwd_data_o  = ex_res;

  // register file write happens on the retire handshake edge
  assign wb_we_o   = wb_valid & wb_we & retire_ready_i;
  assign wb_rd_o   = wb_rd;
  assign wb_data_o = wb_res;

  assign retire_valid_o   = wb_valid;
  assign retire_pc_o      = wb_pc;
  assign retire_rd_o      = wb_rd;
  assign retire_data_o    = wb_res;
  assign retire_we_o      = wb_valid & wb_we;
  assign retire_illegal_o = wb_illegal;

endmodule

//--- hdl/rv_idu.sv
`timescale 1ns/1ps

module rv_idu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid_i,
  input  rv_pipe_pkg::inst_t    inst_i,
  input  rv_pipe_pkg::word_t    pc_i,
  output logic                  inst_ready_o,
  output rv_pipe_pkg::reg_idx_t rs1_o,
  output rv_pipe_pkg::reg_idx_t rs2_o,
  input  rv_pipe_pkg::word_t    rdata1_i,
  input  rv_pipe_pkg::word_t    rdata2_i,
  input  rv_pipe_pkg::rf_busy_t busy_i,
  input  logic                  fwd_valid_i,
  input  rv_pipe_pkg::reg_idx_t fwd_rd_i,
  input  rv_pipe_pkg::word_t    fwd_data_i,
  output logic                  issue_valid_o,
  output rv_isa_pkg::alu_op_e   issue_alu_op_o,
  output rv_pipe_pkg::word_t    issue_op1_o,
  output rv_pipe_pkg::word_t    issue_op2_o,
  output rv_pipe_pkg::reg_idx_t issue_rd_o,
  output logic                  issue_we_o,
  output logic                  issue_illegal_o,
  output rv_pipe_pkg::word_t    issue_pc_o,
  input  logic                  exu_ready_i
);
  import rv_pipe_pkg::*;

  // IDLE means the decode register is empty, HOLD means it has an instruction
  typedef enum logic {
    IDLE,
    HOLD
  } state_e;

  state_e state;
  state_e state_nxt;
  inst_t  d_inst;
  word_t  d_pc;
  word_t  rs1_val;
  word_t  rs2_val;
  logic   uses_rs1;
  logic   uses_rs2;
  logic   fwd_hit1;
  logic   fwd_hit2;
  logic   hazard;
  logic   issue_fire;
  logic   accept;

  // source indices, bit 4 ignored as in RV32E
  assign rs1_o = d_inst[18:15];
  assign rs2_o = d_inst[23:20];

  // execute-stage result wins over the register file
  assign fwd_hit1 = fwd_valid_i & (fwd_rd_i == rs1_o);
  assign fwd_hit2 = fwd_valid_i & (fwd_rd_i == rs2_o);
  assign rs1_val  = fwd_hit1 ? fwd_data_i : rdata1_i;
  assign rs2_val  = fwd_hit2 ? fwd_data_i : rdata2_i;

  // a pending writer that is not in execute sits in writeback,
  // its value is not in the register file yet, so wait
  assign hazard = (uses_rs1 & busy_i[rs1_o] & ~fwd_hit1) |
                  (uses_rs2 & busy_i[rs2_o] & ~fwd_hit2);

  assign issue_valid_o = (state == HOLD) & ~hazard;
  assign issue_fire    = issue_valid_o & exu_ready_i;
  // empty, or emptying on this edge
  assign inst_ready_o  = (state == IDLE) | issue_fire;
  assign accept        = inst_valid_i & inst_ready_o;
  assign issue_pc_o    = d_pc;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (accept) begin
          state_nxt = HOLD;
        end
      end
      HOLD: begin
        // back to back issue keeps the register occupied
        if (issue_fire && !accept) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (accept) begin
      d_inst <= inst_i;
      d_pc   <= pc_i;
    end
  end

  rv_idu_decoder u_decoder (
    .inst_i     (d_inst),
    .pc_i       (d_pc),
    .rs1v_i     (rs1_val),
    .rs2v_i     (rs2_val),
    .rd_o       (issue_rd_o),
    .op1_o      (issue_op1_o),
    .op2_o      (issue_op2_o),
    .alu_op_o   (issue_alu_op_o),
    .we_o       (issue_we_o),
    .illegal_o  (issue_illegal_o),
    .uses_rs1_o (uses_rs1),
    .uses_rs2_o (uses_rs2)
  );

endmodule

//--- hdl/rv_idu_decoder.sv
`timescale 1ns/1ps

module rv_idu_decoder (
  input  rv_pipe_pkg::inst_t    inst_i,
  input  rv_pipe_pkg::word_t    pc_i,
  input  rv_pipe_pkg::word_t    rs1v_i,
  input  rv_pipe_pkg::word_t    rs2v_i,
  output rv_pipe_pkg::reg_idx_t rd_o,
  output rv_pipe_pkg::word_t    op1_o,
  output rv_pipe_pkg::word_t    op2_o,
  output rv_isa_pkg::alu_op_e   alu_op_o,
  output logic                  we_o,
  output logic                  illegal_o,
  output logic                  uses_rs1_o,
  output logic                  uses_rs2_o
);
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  word_t      imm_i;
  word_t      imm_u;

  assign opcode    = opcode_e'(inst_i[6:0]);
  assign funct3    = inst_i[14:12];
  assign funct7_b5 = inst_i[30];

  // rd bit 11 is dropped, RV32E only has x0..x15
  assign rd_o = inst_i[10:7];

  // sign-extended I immediate and U immediate
  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};

  always_comb begin
    op1_o      = '0;
    op2_o      = '0;
    alu_op_o   = ALU_ADD;
    we_o       = 1'b0;
    illegal_o  = 1'b0;
    uses_rs1_o = 1'b0;
    uses_rs2_o = 1'b0;
    case (opcode)
      OP_LUI: begin
        // 0 + imm
        op2_o = imm_u;
        we_o  = 1'b1;
      end
      OP_AUIPC: begin
        op1_o = pc_i;
        op2_o = imm_u;
        we_o  = 1'b1;
      end
      OP_I_TYPE: begin
        op1_o      = rs1v_i;
        op2_o      = imm_i;
        // funct7[5] only counts for srai, for addi etc. it is immediate bits
        alu_op_o   = alu_op_e'({(funct3 == 3'b101) & funct7_b5, funct3});
        we_o       = 1'b1;
        uses_rs1_o = 1'b1;
      end
      OP_R_TYPE: begin
        op1_o      = rs1v_i;
        op2_o      = rs2v_i;
        alu_op_o   = alu_op_e'({funct7_b5, funct3});
        we_o       = 1'b1;
        uses_rs1_o = 1'b1;
        uses_rs2_o = 1'b1;
      end
      default: begin
        // unsupported opcode retires flagged, no register write
        illegal_o = 1'b1;
      end
    endcase
    // x0 as destination never writes and never marks the scoreboard
    if (rd_o == '0) begin
      we_o = 1'b0;
    end
  end

endmodule

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

  // major opcodes handled by this slice
  // everything else decodes as illegal
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_I_TYPE = 7'b0010011,
    OP_R_TYPE = 7'b0110011
  } opcode_e;

  // alu operation, encoded as {funct7[5], funct3}
  // so decode can build it straight from the instruction bits
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    // upper bit set selects the alternate form
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

endpackage

//--- hdl/rv_pipe_pkg.sv
`include "rv_core_params.svh"

package rv_pipe_pkg;

  // pc, operand and result word
  typedef logic [`RV_XLEN-1:0] word_t;

  // architectural register index
  typedef logic [`RV_REG_W-1:0] reg_idx_t;

  // raw 32-bit instruction, always 32 bits wide in the base ISA
  typedef logic [31:0] inst_t;

  // scoreboard count of pending writers for one register
  typedef logic [`RV_CNT_W-1:0] inflight_cnt_t;

  // one busy bit per register
  typedef logic [`RV_NREG-1:0] rf_busy_t;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_pipe_pkg::reg_idx_t raddr1_i,
  input  rv_pipe_pkg::reg_idx_t raddr2_i,
  output rv_pipe_pkg::word_t    rdata1_o,
  output rv_pipe_pkg::word_t    rdata2_o,
  input  logic                  we_i,
  input  rv_pipe_pkg::reg_idx_t waddr_i,
  input  rv_pipe_pkg::word_t    wdata_i
);
  import rv_pipe_pkg::*;

  word_t regs [`RV_NREG];

  // combinational reads
  // a write in the same cycle is not bypassed, decode holds on that case
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // x0 keeps its reset value of zero
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- hdl/rv_scoreboard.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_scoreboard (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  set_i,
  input  rv_pipe_pkg::reg_idx_t set_rd_i,
  input  logic                  clr_i,
  input  rv_pipe_pkg::reg_idx_t clr_rd_i,
  output rv_pipe_pkg::rf_busy_t busy_o
);
  import rv_pipe_pkg::*;

  // pending writers per register, issued but not yet written back
  inflight_cnt_t cnt [`RV_NREG];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREG; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `RV_NREG; i++) begin
        // set and clear on the same index cancel out
        case ({set_i && (set_rd_i == reg_idx_t'(i)), clr_i && (clr_rd_i == reg_idx_t'(i))})
          2'b10:   cnt[i] <= cnt[i] + 1'b1;
          2'b01:   cnt[i] <= cnt[i] - 1'b1;
          default: cnt[i] <= cnt[i];
        endcase
      end
    end
  end

  // busy while any writer is still in flight
  always_comb begin
    for (int i = 0; i < `RV_NREG; i++) begin
      busy_o[i] = (cnt[i] != '0);
    end
  end

endmodule

//--- testbench/rv_core_assertions.sv
`timescale 1ns/1ps

module rv_core_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic                  inst_ready_o,
  input logic                  retire_valid_o,
  input rv_pipe_pkg::word_t    retire_pc_o,
  input rv_pipe_pkg::reg_idx_t retire_rd_o,
  input rv_pipe_pkg::word_t    retire_data_o,
  input logic                  retire_we_o,
  input logic                  retire_illegal_o,
  input logic                  retire_ready_i
);

  // pipeline comes out of reset empty
  retire_idle_after_reset: assert property (@(posedge clk) rst |=> !retire_valid_o)
    else $error("retire_valid_o high in the cycle after reset");

  // decode register starts empty, so input side is ready
  ready_after_reset: assert property (@(posedge clk) rst |=> inst_ready_o)
    else $error("inst_ready_o low in the cycle after reset");

  // a stalled retire record holds every field
  retire_hold: assert property (@(posedge clk) disable iff (rst)
    (retire_valid_o && !retire_ready_i) |=> (retire_valid_o && $stable(retire_pc_o) &&
      $stable(retire_rd_o) && $stable(retire_data_o) && $stable(retire_we_o) &&
      $stable(retire_illegal_o)))
    else $error("retire outputs changed while stalled");

  // no write to x0 and none from an illegal op
  retire_we_legal: assert property (@(posedge clk) disable iff (rst)
    retire_we_o |-> ((retire_rd_o != '0) && !retire_illegal_o))
    else $error("retire_we_o set with rd x0 or with an illegal instruction");

endmodule

bind rv_core_slice rv_core_assertions u_core_assertions (
  .clk              (clk),
  .rst              (rst),
  .inst_ready_o     (inst_ready_o),
  .retire_valid_o   (retire_valid_o),
  .retire_pc_o      (retire_pc_o),
  .retire_rd_o      (retire_rd_o),
  .retire_data_o    (retire_data_o),
  .retire_we_o      (retire_we_o),
  .retire_illegal_o (retire_illegal_o),
  .retire_ready_i   (retire_ready_i)
);

//--- testbench/tb_rv_core_slice.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module tb_rv_core_slice;
  import rv_pipe_pkg::*;
  import rv_isa_pkg::*;

  localparam int NUM_INST   = 400;
  localparam int WAIT_LIMIT = 200;

  // one expected retire record, queued in program order
  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    data;
    logic     we;
    logic     illegal;
  } retire_rec_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        inst_valid_i;
  inst_t       inst_i;
  word_t       pc_i;
  logic        inst_ready_o;
  logic        retire_valid_o;
  word_t       retire_pc_o;
  reg_idx_t    retire_rd_o;
  word_t       retire_data_o;
  logic        retire_we_o;
  logic        retire_illegal_o;
  logic        retire_ready_i;

  // shadow register file of the in-order ISA model
  word_t       shadow [`RV_NREG];
  retire_rec_t expected [$];
  int          n_accepted;
  int          n_retired;
  int          stall;
  logic        accepted;
  logic        retired;
  word_t       next_pc;

  rv_core_slice UUT (
    .clk              (clk),
    .rst              (rst),
    .inst_valid_i     (inst_valid_i),
    .inst_i           (inst_i),
    .pc_i             (pc_i),
    .inst_ready_o     (inst_ready_o),
    .retire_valid_o   (retire_valid_o),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o),
    .retire_we_o      (retire_we_o),
    .retire_illegal_o (retire_illegal_o),
    .retire_ready_i   (retire_ready_i)
  );

  always #5 clk = ~clk;

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic compare_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0d ns: %s is %08h, expected %08h", $time, what, got, exp));
    end
  endtask

  task automatic compare_idx(string what, reg_idx_t got, reg_idx_t exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0d ns: %s is x%0d, expected x%0d", $time, what, got, exp));
    end
  endtask

  task automatic compare_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      stop_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // mostly x0..x5 so that nearby instructions depend on each other
  function automatic logic [4:0] pick_reg();
    if ($urandom_range(7, 0) != 0) begin
      return 5'($urandom_range(5, 0));
    end
    // field bit 4 is ignored by RV32E decode
    return 5'($urandom_range(31, 0));
  endfunction

  // random instruction, with an occasional unsupported opcode
  function automatic inst_t random_inst();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    logic [6:0]  op;
    int          kind;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = 3'($urandom_range(7, 0));
    alt  = 1'($urandom_range(1, 0));
    imm  = 12'($urandom);
    kind = int'($urandom_range(15, 0));
    if (kind < 6) begin
      // funct7 bit 5 only exists for sub and sra
      return {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0, rs2, rs1, f3, rd, OP_R_TYPE};
    end
    if (kind < 12) begin
      // shift immediates keep 31:25 clear apart from the srai bit
      if (f3 == 3'b001 || f3 == 3'b101) begin
        imm[11:5] = {1'b0, alt && (f3 == 3'b101), 5'b0};
      end
      return {imm, rs1, f3, rd, OP_I_TYPE};
    end
    if (kind == 12) begin
      return {20'($urandom), rd, OP_LUI};
    end
    if (kind == 13) begin
      return {20'($urandom), rd, OP_AUIPC};
    end
    // flipping bit 6 moves a supported opcode out of the set
    op = 7'($urandom);
    if (op == OP_LUI || op == OP_AUIPC || op == OP_I_TYPE || op == OP_R_TYPE) begin
      op = op ^ 7'b1000000;
    end
    return {25'($urandom), op};
  endfunction

  // RV32I integer operation table, alt is funct7 bit 5
  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << y[4:0];
      3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3:    return (x < y) ? 32'd1 : 32'd0;
      3'd4:    return x ^ y;
      3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  // executes one accepted instruction in program order
  task automatic model_accept(inst_t inst, word_t pc);
    retire_rec_t rec;
    word_t       a;
    word_t       imm_i;
    word_t       imm_u;
    a           = shadow[inst[18:15]];
    imm_i       = {{20{inst[31]}}, inst[31:20]};
    imm_u       = {inst[31:12], 12'b0};
    rec.pc      = pc;
    rec.rd      = inst[10:7];
    rec.data    = '0;
    rec.illegal = 1'b0;
    case (inst[6:0])
      OP_LUI:    rec.data = imm_u;
      OP_AUIPC:  rec.data = pc + imm_u;
      // srai is the only I-type op that reads bit 30
      OP_I_TYPE: rec.data = alu_ref(inst[14:12], inst[14:12] == 3'b101 && inst[30], a, imm_i);
      OP_R_TYPE: rec.data = alu_ref(inst[14:12], inst[30], a, shadow[inst[23:20]]);
      default:   rec.illegal = 1'b1;
    endcase
    // x0 stays zero and illegal ops touch nothing
    rec.we = !rec.illegal && (rec.rd != '0);
    if (rec.we) begin
      shadow[rec.rd] = rec.data;
    end
    expected.push_back(rec);
    n_accepted++;
  endtask

  task automatic check_retire();
    retire_rec_t rec;
    string       tag;
    if (expected.size() == 0) begin
      stop_run("the retire port delivered an instruction that was never accepted");
    end
    rec = expected.pop_front();
    tag = $sformatf("retire %0d (pc %08h)", n_retired, rec.pc);
    compare_word({tag, " pc"}, retire_pc_o, rec.pc);
    compare_flag({tag, " illegal"}, retire_illegal_o, rec.illegal);
    compare_flag({tag, " we"}, retire_we_o, rec.we);
    // rd and data carry no meaning for an illegal op
    if (!rec.illegal) begin
      compare_idx({tag, " rd"}, retire_rd_o, rec.rd);
      compare_word({tag, " data"}, retire_data_o, rec.data);
    end
    n_retired++;
  endtask

  // handshakes are read at the edge, before any register updates land
  task automatic sample_edge();
    @(posedge clk);
    accepted = inst_valid_i && inst_ready_o;
    retired  = retire_valid_o && retire_ready_i;
    if (accepted) begin
      model_accept(inst_i, pc_i);
    end
    if (retired) begin
      check_retire();
    end
  endtask

  // next inputs, source holds its data until accepted
  task automatic drive_next();
    retire_ready_i <= ($urandom_range(3, 0) != 0);
    if (!inst_valid_i || accepted) begin
      if (n_accepted < NUM_INST && $urandom_range(4, 0) != 0) begin
        inst_i       <= random_inst();
        pc_i         <= next_pc;
        next_pc      = next_pc + 32'd4;
        inst_valid_i <= 1'b1;
      end else begin
        inst_valid_i <= 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(19));
    rst            = 1'b1;
    inst_valid_i   = 1'b0;
    inst_i         = '0;
    pc_i           = '0;
    retire_ready_i = 1'b0;
    accepted       = 1'b0;
    retired        = 1'b0;
    n_accepted     = 0;
    n_retired      = 0;
    next_pc        = 32'h0000_1000;
    for (int i = 0; i < `RV_NREG; i++) begin
      shadow[i] = '0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // feed the stream, retires are checked as they come
    stall = 0;
    while (n_accepted < NUM_INST) begin
      sample_edge();
      stall = accepted ? 0 : stall + 1;
      if (stall > WAIT_LIMIT) begin
        stop_run("timeout: decode stopped accepting instructions");
      end
      drive_next();
    end

    // drain whatever is still in flight
    stall = 0;
    while (n_retired < NUM_INST) begin
      sample_edge();
      stall = retired ? 0 : stall + 1;
      if (stall > WAIT_LIMIT) begin
        stop_run("timeout: accepted instructions never reached the retire port");
      end
      drive_next();
    end

    // one more edge so the last writeback lands in the register file
    @(posedge clk);
    compare_flag("retire valid after the last instruction", retire_valid_o, 1'b0);
    for (int i = 0; i < `RV_NREG; i++) begin
      compare_word($sformatf("x%0d at end of run", i), UUT.u_regfile.regs[i], shadow[i]);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_regfile.sv
hdl/rv_scoreboard.sv
hdl/rv_idu_decoder.sv
hdl/rv_idu.sv
hdl/rv_exu.sv
hdl/rv_core_slice.sv
testbench/rv_core_assertions.sv
testbench/tb_rv_core_slice.sv
